//--- project.f
+incdir+testbench
verilog/zx_port_pkg.sv
verilog/zx_conf_pkg.sv
verilog/port_bus_if.sv
verilog/port_decode.sv
verilog/mem_pager.sv
verilog/xt_regs.sv
verilog/sd_port.sv
verilog/port_readback.sv
verilog/zports.sv
testbench/tb_zports.sv

//--- Bender.yml
package:
  name: zports

sources:
  - verilog/zx_port_pkg.sv
  - verilog/zx_conf_pkg.sv
  - verilog/port_bus_if.sv
  - verilog/port_decode.sv
  - verilog/mem_pager.sv
  - verilog/xt_regs.sv
  - verilog/sd_port.sv
  - verilog/port_readback.sv
  - verilog/zports.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_zports.sv

//--- testbench/tb_zports_tasks.svh
// bus cycles, value check and directed tests of the i/o port block
`ifndef TB_ZPORTS_TASKS_SVH
`define TB_ZPORTS_TASKS_SVH

task automatic check(input string name, input logic [31:0] actual,
	input logic [31:0] expected);
	check_count++;
	if (actual !== expected)
	begin
		err_count++;
		$display("mismatch %s: got %h, expected %h at %0t", name, actual, expected, $time);
	end
endtask

task automatic sample_bus();
	seen_dout    = dout;
	seen_dataout = dataout;
	seen_start   = sd_start;
	seen_sd_byte = sd_datain;
endtask

// one strobe cycle that returns at the negedge after the register edge
task automatic io_write(input logic [15:0] addr, input byte_t data);
	@(posedge clk);
	a      <= addr;
	din    <= data;
	wr     <= 1'b1;
	iowr_s <= 1'b1;
	@(negedge clk);
	sample_bus();
	@(posedge clk);
	wr     <= 1'b0;
	iowr_s <= 1'b0;
	@(negedge clk);
endtask

task automatic io_read(input logic [15:0] addr);
	@(posedge clk);
	a      <= addr;
	wr     <= 1'b0;
	iord_s <= 1'b1;
	@(negedge clk);
	sample_bus();
	@(posedge clk);
	iord_s <= 1'b0;
	@(negedge clk);
endtask

task automatic opcode_fetch(input byte_t op);
	@(posedge clk);
	din     <= op;
	opfetch <= 1'b1;
	@(posedge clk);
	opfetch <= 1'b0;
endtask

// window 3 after a #7FFD write in each lock mode
function automatic byte_t page_from_7ffd(input logic [1:0] mode, input byte_t d,
	input logic fetch_eq);
	case (mode)
		2'd0:    page_from_7ffd = {3'b000, d[7:6], d[2:0]};
		2'd1:    page_from_7ffd = {5'b00000, d[2:0]};
		2'd2:    page_from_7ffd = fetch_eq ? {5'b00000, d[2:0]} : {3'b000, d[7:6], d[2:0]};
		default: page_from_7ffd = {2'b00, d[5], d[7:6], d[2:0]};
	endcase
endfunction

function automatic logic port_is_hit(input byte_t lo, input logic in_dos);
	case (lo)
		8'hFE, 8'hAF, 8'hFD, 8'hDF: port_is_hit = 1'b1;
		8'h1F, 8'h77, 8'h57:        port_is_hit = !in_dos; // vdos low here
		default:                    port_is_hit = 1'b0;
	endcase
endfunction

task automatic reset_values_hold();
	check("sysconf", sysconf, 8'h01);
	check("memconf", memconf, 8'h04);
	check("cacheconf", cacheconf, 4'h0);
	check("intmask", intmask, 8'h01);
	check("xt_page", xt_page, 32'h00020500);
	check("fmaddr[4]", fmaddr[4], 1'b0);
	check("fddvirt", fddvirt, 4'h0);
	check("sdcs_n", sdcs_n, 1'b1);
endtask

task automatic xt_registers_load();
	byte_t b;
	byte_t pages [4];
	int    i;
	for (i = 0; i < 4; i++)
	begin
		random_byte(b);
		pages[i] = b;
		io_write({XT_RAMPAGE + byte_t'(i), PORT_XT}, b);
		check($sformatf("xt_page window %0d", i), xt_page[8 * i +: 8], b);
	end
	io_read({XT_RAMPAGE + 8'd2, PORT_XT});
	check("dout rampage 2", seen_dout, pages[2]);
	io_read({XT_RAMPAGE + 8'd3, PORT_XT});
	check("dout rampage 3", seen_dout, pages[3]);

	random_byte(b);
	io_write({XT_FMADDR, PORT_XT}, b);
	check("fmaddr", fmaddr, b[4:0]);
	random_byte(b);
	for (i = 0; i < 2; i++)
	begin
		io_write({XT_SYSCONF, PORT_XT}, b);
		check("sysconf", sysconf, b);
		check("cacheconf copy", cacheconf, {4{b[2]}});
		b = b ^ 8'h04; // second pass with the other bit 2
	end
	random_byte(b);
	io_write({XT_CACHECONF, PORT_XT}, b);
	check("cacheconf", cacheconf, b[3:0]);
	random_byte(b);
	io_write({XT_FDDVIRT, PORT_XT}, b);
	check("fddvirt", fddvirt, b[3:0]);
	random_byte(b);
	io_write({XT_INTMASK, PORT_XT}, b);
	check("intmask", intmask, b);
	random_byte(b);
	io_write({XT_MEMCONF, PORT_XT}, b);
	check("memconf", memconf, b);
endtask

task automatic legacy_paging();
	byte_t      b;
	byte_t      op;
	byte_t      page3;
	logic       rom0;
	logic [1:0] mode;
	int         i;
	int         n;
	for (i = 0; i < 3; i++)
	begin
		mode = (i == 2) ? 2'd3 : 2'(i);
		io_write({XT_MEMCONF, PORT_XT}, {mode, 6'b000100});
		for (n = 0; n < 3; n++)
		begin
			random_byte(b);
			b[5] = (mode == 2'd3); // page bit in mode 3, lock otherwise
			io_write({8'h7F, PORT_FD}, b);
			check("window 3", xt_page[31:24], page_from_7ffd(mode, b, 1'b0));
			check("memconf[0]", memconf[0], b[4]);
		end
	end

	// fetch-controlled lock over all four combinations of opcode bits 7:6
	io_write({XT_MEMCONF, PORT_XT}, 8'h84);
	for (i = 0; i < 4; i++)
	begin
		random_byte(b);
		op = {2'(i), b[5:0]};
		opcode_fetch(op);
		random_byte(b);
		b[7:5] = 3'b110;
		io_write({8'h7F, PORT_FD}, b);
		check("window 3 mode 2", xt_page[31:24], page_from_7ffd(2'd2, b, op[7] == op[6]));
	end

	// #FFFD is the sound chip
	page3 = page_from_7ffd(2'd2, b, op[7] == op[6]);
	rom0  = b[4];
	io_write({8'hFF, PORT_FD}, {3'b111, ~rom0, 1'b0, ~page3[2:0]});
	check("window 3 A15 high", xt_page[31:24], page3);
	check("memconf[0] A15 high", memconf[0], rom0);

	io_write({XT_MEMCONF, PORT_XT}, 8'h04);
	page3 = page_from_7ffd(2'd0, 8'h23, 1'b0);
	io_write({8'h7F, PORT_FD}, 8'h23); // bit 5 sets lock48
	check("window 3 locking", xt_page[31:24], page3);
	io_write({8'h7F, PORT_FD}, 8'h54);
	check("window 3 locked", xt_page[31:24], page3);
	check("memconf[0] locked", memconf[0], 1'b0); // bit 4 of #23
	apply_reset();
	io_write({8'h7F, PORT_FD}, 8'h54);
	check("window 3 after reset", xt_page[31:24], page_from_7ffd(2'd0, 8'h54, 1'b0));
	check("memconf[0] after reset", memconf[0], 1'b1);
endtask

task automatic readback_mux();
	byte_t k;
	byte_t j;
	byte_t m;
	random_byte(k);
	random_byte(j);
	random_byte(m);
	@(posedge clk);
	keys_in   <= k[4:0];
	tape_read <= k[7];
	kj_in     <= j[4:0];
	mus_in    <= m;
	io_read({8'h00, PORT_FE});
	check("dout #FE", seen_dout, {1'b1, k[7], 1'b0, k[4:0]});
	check("dataout #FE", seen_dataout, 1'b1);
	io_read({8'h00, PORT_KJOY});
	check("dout #1F", seen_dout, {3'b000, j[4:0]});
	check("dataout #1F", seen_dataout, 1'b1);
	@(posedge clk);
	dos <= 1'b1;
	io_read({8'h00, PORT_KJOY});
	check("dataout #1F in dos", seen_dataout, 1'b0);
	@(posedge clk);
	dos <= 1'b0;
	io_read({8'h00, PORT_KMOUSE});
	check("dout #DF", seen_dout, m);

	// power-up flag shows one cycle after each status read
	io_read({XT_XSTAT, PORT_XT});
	check("dout[6] status first", dout[6], 1'b1);
	io_read({XT_XSTAT, PORT_XT});
	check("dout[6] status second", dout[6], 1'b0);

	@(posedge clk);
	dma_act <= 1'b1;
	io_read({XT_DMASTAT, PORT_XT});
	check("dout dma busy", seen_dout, 8'h80);
	@(posedge clk);
	dma_act <= 1'b0;
	io_read({XT_DMASTAT, PORT_XT});
	check("dout dma idle", seen_dout, 8'h00);
	io_read(16'h0033);
	check("dout unlisted", seen_dout, 8'hFF);
	check("dataout unlisted", seen_dataout, 1'b0);
	io_write({8'h00, PORT_FE}, 8'h00);
	check("dataout on write", seen_dataout, 1'b0);
endtask

task automatic sd_port_access();
	byte_t b;
	io_write({8'h00, PORT_SDCFG}, 8'h00);
	check("sdcs_n low", sdcs_n, 1'b0);
	io_write({8'h00, PORT_SDCFG}, 8'h02);
	check("sdcs_n high", sdcs_n, 1'b1);
	@(posedge clk);
	dos <= 1'b1;
	io_write({8'h00, PORT_SDCFG}, 8'h00);
	check("sdcs_n in dos", sdcs_n, 1'b1);
	@(posedge clk);
	vdos <= 1'b1;
	io_write({8'h00, PORT_SDCFG}, 8'h00);
	check("sdcs_n in vdos", sdcs_n, 1'b0);
	@(posedge clk);
	dos  <= 1'b0;
	vdos <= 1'b0;

	random_byte(b);
	io_write({8'h00, PORT_SDDAT}, b);
	check("sd_start write", seen_start, 1'b1);
	check("sd_datain write", seen_sd_byte, b);
	random_byte(b);
	@(posedge clk);
	sd_dataout <= b;
	io_read({8'h00, PORT_SDDAT});
	check("sd_start read", seen_start, 1'b1);
	check("sd_datain read", seen_sd_byte, 8'hFF);
	check("dout #57", seen_dout, b);
	check("sd_start idle", sd_start, 1'b0);
	io_read({8'h00, PORT_SDCFG});
	check("dout #77", seen_dout, 8'h00);
	check("sd_start #77", seen_start, 1'b0);
	@(posedge clk);
	dos <= 1'b1;
	io_read({8'h00, PORT_SDDAT});
	check("sd_start in dos", seen_start, 1'b0);
	check("dataout #57 in dos", seen_dataout, 1'b0);
	@(posedge clk);
	dos <= 1'b0;
endtask

task automatic porthit_sweep();
	int d;
	int lo;
	for (d = 0; d < 2; d++)
	begin
		for (lo = 0; lo < 256; lo++)
		begin
			@(posedge clk);
			a   <= {8'h00, byte_t'(lo)};
			dos <= d[0];
			@(negedge clk);
			check($sformatf("porthit #%02h dos %0d", lo, d), porthit,
				port_is_hit(byte_t'(lo), d[0]));
		end
	end
	@(posedge clk);
	dos <= 1'b0;
endtask

`endif

//--- testbench/tb_zports.sv
// testbench of the z80 i/o port block, directed tests with a pass or fail verdict
`timescale 1ns/1ps

module tb_zports;
	import zx_port_pkg::*;
	import zx_conf_pkg::*;

	localparam int CYCLE_LIMIT = 2000; // about three times the test length

	logic        clk;
	logic        rst;
	logic [7:0]  din;
	logic [15:0] a;
	logic        opfetch;
	logic        iord_s;
	logic        iowr_s;
	logic        wr;
	logic        dos;
	logic        vdos;
	logic [4:0]  keys_in;
	logic        tape_read;
	logic [4:0]  kj_in;
	logic [7:0]  mus_in;
	logic [7:0]  sd_dataout;
	logic        dma_act;
	logic [7:0]  dout;
	logic        dataout;
	logic        porthit;
	logic [31:0] xt_page;
	logic [4:0]  fmaddr;
	logic [7:0]  sysconf;
	logic [7:0]  memconf;
	logic [3:0]  cacheconf;
	logic [3:0]  fddvirt;
	logic [7:0]  intmask;
	logic        sdcs_n;
	logic        sd_start;
	logic [7:0]  sd_datain;

	int          err_count = 0;
	int          check_count = 0;
	int          cycle_count = 0;
	logic [15:0] lfsr = 16'd61941;

	// combinational outputs as seen in the middle of a strobe cycle
	byte_t seen_dout;
	logic  seen_dataout;
	logic  seen_start;
	byte_t seen_sd_byte;

	zports dut0 (.*);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// galois lfsr, x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		lfsr_next = {1'b0, s[15:1]};
		if (s[0])
			lfsr_next = lfsr_next ^ 16'hB400;
	endfunction

	// one lfsr step per bit taken
	task automatic random_byte(output byte_t b);
		int i;
		for (i = 0; i < 8; i++)
		begin
			b[i] = lfsr[0];
			lfsr = lfsr_next(lfsr);
		end
	endtask

	task automatic apply_reset();
		@(posedge clk);
		rst <= 1'b1;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
	endtask

	`include "tb_zports_tasks.svh"

	always @(posedge clk)
		cycle_count <= cycle_count + 1;

	initial
	begin
		wait (cycle_count >= CYCLE_LIMIT);
		$display("timeout: tests still running after %0d cycles", CYCLE_LIMIT);
		$display("Simulation failed");
		$finish;
	end

	initial
	begin
		rst        <= 1'b1;
		din        <= 8'h00;
		a          <= 16'h0000;
		opfetch    <= 1'b0;
		iord_s     <= 1'b0;
		iowr_s     <= 1'b0;
		wr         <= 1'b0;
		dos        <= 1'b0;
		vdos       <= 1'b0;
		keys_in    <= 5'h1F;
		tape_read  <= 1'b0;
		kj_in      <= 5'h00;
		mus_in     <= 8'hFF;
		sd_dataout <= 8'hFF;
		dma_act    <= 1'b0;
		apply_reset();

		reset_values_hold();
		xt_registers_load();
		legacy_paging();
		readback_mux();
		sd_port_access();
		porthit_sweep();

		$display("errors: %0d in %0d checks", err_count, check_count);
		if (err_count == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

//--- verilog/zports.sv
// z80 i/o port block: decoder, paging and config registers, sd port and read-back
`timescale 1ns/1ps

module zports (
	input  logic        clk,
	input  logic        rst,
	input  logic [7:0]  din,
	input  logic [15:0] a,
	input  logic        opfetch,
	input  logic        iord_s,
	input  logic        iowr_s,
	input  logic        wr,
	input  logic        dos,
	input  logic        vdos,
	input  logic [4:0]  keys_in,
	input  logic        tape_read,
	input  logic [4:0]  kj_in,
	input  logic [7:0]  mus_in,
	input  logic [7:0]  sd_dataout,
	input  logic        dma_act,
	output logic [7:0]  dout,
	output logic        dataout,
	output logic        porthit,
	output logic [31:0] xt_page,
	output logic [4:0]  fmaddr,
	output logic [7:0]  sysconf,
	output logic [7:0]  memconf,
	output logic [3:0]  cacheconf,
	output logic [3:0]  fddvirt,
	output logic [7:0]  intmask,
	output logic        sdcs_n,
	output logic        sd_start,
	output logic [7:0]  sd_datain
);

	port_bus_if pbus ();

	port_decode u_decode (
		.a       (a),
		.iowr_s  (iowr_s),
		.iord_s  (iord_s),
		.dos     (dos),
		.vdos    (vdos),
		.din     (din),
		.porthit (porthit),
		.pbus    (pbus.decoder)
	);

	mem_pager u_pager (
		.clk     (clk),
		.rst     (rst),
		.opfetch (opfetch),
		.din     (din),
		.pbus    (pbus.sink),
		.xt_page (xt_page),
		.memconf (memconf)
	);

	xt_regs u_xt (
		.clk       (clk),
		.rst       (rst),
		.pbus      (pbus.sink),
		.fmaddr    (fmaddr),
		.sysconf   (sysconf),
		.cacheconf (cacheconf),
		.fddvirt   (fddvirt),
		.intmask   (intmask)
	);

	sd_port u_sd (
		.clk       (clk),
		.rst       (rst),
		.wr        (wr),
		.pbus      (pbus.sink),
		.sdcs_n    (sdcs_n),
		.sd_start  (sd_start),
		.sd_datain (sd_datain)
	);

	port_readback u_rdback (
		.clk        (clk),
		.a          (a),
		.iord_s     (iord_s),
		.dos        (dos),
		.vdos       (vdos),
		.keys_in    (keys_in),
		.tape_read  (tape_read),
		.kj_in      (kj_in),
		.mus_in     (mus_in),
		.sd_dataout (sd_dataout),
		.dma_act    (dma_act),
		.xt_page    (xt_page),
		.dout       (dout),
		.dataout    (dataout)
	);

endmodule

//--- verilog/port_readback.sv
// read-back multiplexer for the cpu, data-out enable and the power-up status flag
`timescale 1ns/1ps

module port_readback (
	input  logic               clk,
	input  logic [15:0]        a,
	input  logic               iord_s,
	input  logic               dos,
	input  logic               vdos,
	input  logic [4:0]         keys_in,
	input  logic               tape_read,
	input  logic [4:0]         kj_in,
	input  zx_port_pkg::byte_t mus_in,
	input  zx_port_pkg::byte_t sd_dataout,
	input  logic               dma_act,
	input  logic [31:0]        xt_page,
	output zx_port_pkg::byte_t dout,
	output logic               dataout
);
	import zx_port_pkg::*;

	byte_t loa;
	byte_t hoa;
	byte_t xt_dout;
	logic  hit;
	logic  pwr_up = 1'b1;      // set by fpga configuration only
	logic  pwr_up_reg = 1'b0;  // value returned by the last status read

	assign loa = a[7:0];
	assign hoa = a[15:8];

	assign hit = (loa == PORT_FE) || (loa == PORT_XT) || (loa == PORT_FD)
		|| (loa == PORT_KMOUSE) || ((loa == PORT_KJOY) && !dos)
		|| (((loa == PORT_SDCFG) || (loa == PORT_SDDAT)) && sd_allowed(dos, vdos));

	assign dataout = hit && iord_s;

	always @(posedge clk)
	begin
		if (iord_s && (loa == PORT_XT) && (hoa == XT_XSTAT))
		begin
			pwr_up_reg <= pwr_up;
			pwr_up     <= 1'b0;
		end
	end

	always_comb
	begin
		case (hoa)
			XT_XSTAT:                           xt_dout = {1'b0, pwr_up_reg, 6'b000000};
			XT_DMASTAT:                         xt_dout = {dma_act, 7'b0000000};
			XT_RAMPAGE + 8'd2, XT_RAMPAGE + 8'd3: xt_dout = xt_page[{hoa[1:0], 3'b000} +: 8];
			default:                            xt_dout = BUS_IDLE;
		endcase
	end

	always_comb
	begin
		case (loa)
			PORT_FE:     dout = {1'b1, tape_read, 1'b0, keys_in};
			PORT_XT:     dout = xt_dout;
			PORT_KJOY:   dout = {3'b000, kj_in};
			PORT_KMOUSE: dout = mus_in;
			PORT_SDCFG:  dout = 8'h00; // card present, not write protected
			PORT_SDDAT:  dout = sd_dataout;
			default:     dout = BUS_IDLE;
		endcase
	end

endmodule

//--- verilog/sd_port.sv
// sd card spi control: chip select, transfer start and the byte sent to the card
`timescale 1ns/1ps

module sd_port (
	input  logic               clk,
	input  logic               rst,
	input  logic               wr,
	port_bus_if.sink           pbus,
	output logic               sdcs_n,
	output logic               sd_start,
	output zx_port_pkg::byte_t sd_datain
);

	// chip select sits in bit 1 of the control port
	always_ff @(posedge clk)
	begin
		if (rst)
			sdcs_n <= 1'b1;
		else if (pbus.sd_cfg_wr)
			sdcs_n <= pbus.data[1];
	end

	// every data port access, read or write, shifts one byte
	assign sd_start = pbus.sd_dat_wr || pbus.sd_dat_rd;

	// a read clocks out all ones
	assign sd_datain = wr ? pbus.data : 8'hFF;

endmodule

//--- verilog/xt_regs.sv
// remaining #nnAF registers for fm address, sysconf, cacheconf, fdd virtual and int mask
`timescale 1ns/1ps

module xt_regs (
	input  logic               clk,
	input  logic               rst,
	port_bus_if.sink           pbus,
	output logic [4:0]         fmaddr,
	output zx_port_pkg::byte_t sysconf,
	output logic [3:0]         cacheconf,
	output logic [3:0]         fddvirt,
	output zx_port_pkg::byte_t intmask
);
	import zx_port_pkg::*;
	import zx_conf_pkg::*;

	logic ld_fmaddr;
	logic ld_sysconf;
	logic ld_cacheconf;
	logic ld_fddvirt;
	logic ld_intmask;

	assign ld_fmaddr    = pbus.xt_wr && (pbus.xt_idx == XT_FMADDR);
	assign ld_sysconf   = pbus.xt_wr && (pbus.xt_idx == XT_SYSCONF);
	assign ld_cacheconf = pbus.xt_wr && (pbus.xt_idx == XT_CACHECONF);
	assign ld_fddvirt   = pbus.xt_wr && (pbus.xt_idx == XT_FDDVIRT);
	assign ld_intmask   = pbus.xt_wr && (pbus.xt_idx == XT_INTMASK);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			fmaddr[4] <= 1'b0;  // only the fm access bit is reset
			sysconf   <= SYSCONF_RST;
			cacheconf <= CACHECONF_RST;
			fddvirt   <= 4'h0;
			intmask   <= INTMASK_RST;
		end
		else
		begin
			if (ld_fmaddr)
				fmaddr <= pbus.data[4:0];
			if (ld_sysconf)
			begin
				sysconf   <= pbus.data;
				cacheconf <= {4{pbus.data[2]}}; // cache all windows or none
			end
			if (ld_cacheconf)
				cacheconf <= pbus.data[3:0];
			if (ld_fddvirt)
				fddvirt <= pbus.data[3:0];
			if (ld_intmask)
				intmask <= pbus.data;
		end
	end

	// index decode needs a known high address byte
	a_idx_known: assert property (@(posedge clk) disable iff (rst)
		pbus.xt_wr |-> !$isunknown(pbus.xt_idx));

endmodule

//--- verilog/mem_pager.sv
// ram window pages, memconf and the #7FFD legacy paging with its lock modes
`timescale 1ns/1ps

module mem_pager (
	input  logic               clk,
	input  logic               rst,
	input  logic               opfetch,
	input  zx_port_pkg::byte_t din,
	port_bus_if.sink           pbus,
	output logic [31:0]        xt_page,
	output zx_port_pkg::byte_t memconf
);
	import zx_port_pkg::*;
	import zx_conf_pkg::*;

	page_t      rampage [4];
	logic       lock48;     // 48k lock, freezes #7FFD until reset
	logic       fetch_eq;   // bits 7 and 6 of the last opcode are equal
	lock_mode_t lock_mode;
	logic [2:0] win3_hi;    // upper page bits from a #7FFD write
	logic       p7ffd_wr;

	assign lock_mode = lock_mode_t'(memconf[7:6]);
	assign p7ffd_wr  = pbus.fd_wr && !lock48;
	assign xt_page   = {rampage[3], rampage[2], rampage[1], rampage[0]};

	always_comb
	begin
		case (lock_mode)
			LOCK_OFF:   win3_hi = {1'b0, pbus.data[7:6]};
			LOCK_128:   win3_hi = 3'b000;
			LOCK_FETCH: win3_hi = fetch_eq ? 3'b000 : {1'b0, pbus.data[7:6]};
			default:    win3_hi = {pbus.data[5], pbus.data[7:6]};
		endcase
	end

	// opcode sample, din holds the fetched opcode in an opfetch cycle
	always_ff @(posedge clk)
	begin
		if (rst)
			fetch_eq <= 1'b0;
		else if (opfetch)
			fetch_eq <= (din[7] == din[6]);
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			memconf    <= MEMCONF_RST;
			rampage[0] <= RAMPAGE_RST0;
			rampage[1] <= RAMPAGE_RST1;
			rampage[2] <= RAMPAGE_RST2;
			rampage[3] <= RAMPAGE_RST3;
		end
		else if (p7ffd_wr)
		begin
			memconf[0] <= pbus.data[4];  // rom select
			rampage[3] <= {2'b00, win3_hi, pbus.data[2:0]};
		end
		else if (pbus.xt_wr)
		begin
			if (pbus.xt_idx[7:2] == XT_RAMPAGE[7:2])
				rampage[pbus.xt_idx[1:0]] <= pbus.data;
			if (pbus.xt_idx == XT_MEMCONF)
				memconf <= pbus.data;
		end
	end

	// bit 5 is a page bit in the extended mode, not a lock
	always_ff @(posedge clk)
	begin
		if (rst)
			lock48 <= 1'b0;
		else if (p7ffd_wr && lock_mode != LOCK_EXT)
			lock48 <= pbus.data[5];
	end

	// once locked, a #7FFD write from the decoder must leave window 3 alone
	a_lock48_freeze: assert property (@(posedge clk) disable iff (rst)
		pbus.fd_wr && lock48 |=> $stable(xt_page[31:24]));

endmodule

//--- verilog/port_decode.sv
// port address decoder, raises porthit and the per-port write and read strobes
`timescale 1ns/1ps

module port_decode (
	input  logic [15:0]        a,
	input  logic               iowr_s,
	input  logic               iord_s,
	input  logic               dos,
	input  logic               vdos,
	input  zx_port_pkg::byte_t din,
	output logic               porthit,
	port_bus_if.decoder        pbus
);
	import zx_port_pkg::*;

	byte_t loa;
	byte_t hoa;
	logic  sd_on;    // sd ports visible in this mode
	logic  hit_fe;
	logic  hit_xt;
	logic  hit_fd;
	logic  hit_joy;
	logic  hit_mouse;
	logic  hit_sdcfg;
	logic  hit_sddat;

	assign loa   = a[7:0];
	assign hoa   = a[15:8];
	assign sd_on = sd_allowed(dos, vdos);

	assign hit_fe    = (loa == PORT_FE);
	assign hit_xt    = (loa == PORT_XT);
	assign hit_fd    = (loa == PORT_FD);  // #FFFD sound chip counts too
	assign hit_joy   = (loa == PORT_KJOY) && !dos; // fdc owns #1F in dos
	assign hit_mouse = (loa == PORT_KMOUSE);
	assign hit_sdcfg = (loa == PORT_SDCFG) && sd_on;
	assign hit_sddat = (loa == PORT_SDDAT) && sd_on;

	always_comb
	begin
		porthit = hit_fe || hit_xt || hit_fd || hit_mouse || hit_joy;
		if (hit_sdcfg || hit_sddat)
			porthit = 1'b1;
	end

	assign pbus.data   = din;
	assign pbus.xt_idx = hoa;

	// writes act in the single strobe cycle
	assign pbus.xt_wr = hit_xt && iowr_s;
	assign pbus.fd_wr = hit_fd && !a[15] && iowr_s; // #7FFD only, A15 low

	always_comb
	begin
		pbus.sd_cfg_wr = 1'b0;
		pbus.sd_dat_wr = 1'b0;
		pbus.sd_dat_rd = 1'b0;
		if (hit_sdcfg)
			pbus.sd_cfg_wr = iowr_s;
		if (hit_sddat)
		begin
			pbus.sd_dat_wr = iowr_s;
			pbus.sd_dat_rd = iord_s;
		end
	end

endmodule

//--- verilog/port_bus_if.sv
// decoded i/o write strobes and the cpu data byte, from the port decoder to the registers
`timescale 1ns/1ps

interface port_bus_if;
	import zx_port_pkg::*;

	byte_t data;      // cpu byte
	byte_t xt_idx;    // high address byte, #nnAF register index
	logic  xt_wr;     // write to #nnAF
	logic  fd_wr;     // write to #7FFD, before the lock48 check
	logic  sd_cfg_wr; // sd control write
	logic  sd_dat_wr; // sd data write
	logic  sd_dat_rd; // sd data read

	modport decoder (
		output data, xt_idx, xt_wr, fd_wr,
		output sd_cfg_wr, sd_dat_wr, sd_dat_rd
	);

	modport sink (
		input data, xt_idx, xt_wr, fd_wr,
		input sd_cfg_wr, sd_dat_wr, sd_dat_rd
	);

endinterface

//--- verilog/zx_conf_pkg.sv
// configuration register types and reset values of the memory and system setup
package zx_conf_pkg;

	// memconf[7:6], how #7FFD may reach the upper ram pages
	typedef enum logic [1:0] {
		LOCK_OFF   = 2'd0, // data bits 7:6 extend the page
		LOCK_128   = 2'd1, // plain 128k, upper bits held at zero
		LOCK_FETCH = 2'd2, // lock decided by the last opcode fetched
		LOCK_EXT   = 2'd3  // 1m extension through data bit 5
	} lock_mode_t;

	typedef logic [7:0] page_t; // one ram window page number

	localparam logic [7:0] SYSCONF_RST   = 8'h01; // 7 MHz turbo
	localparam logic [7:0] MEMCONF_RST   = 8'h04; // rom mapping off
	localparam logic [7:0] INTMASK_RST   = 8'h01; // frame int only
	localparam logic [3:0] CACHECONF_RST = 4'h0;  // no cache windows

	// window 0..3 after reset, rom, page 5, page 2, page 0
	localparam page_t RAMPAGE_RST0 = 8'h00;
	localparam page_t RAMPAGE_RST1 = 8'h05;
	localparam page_t RAMPAGE_RST2 = 8'h02;
	localparam page_t RAMPAGE_RST3 = 8'h00;

endpackage

//--- verilog/zx_port_pkg.sv
// port map of the z80 i/o block: low address byte codes and #nnAF register indexes
package zx_port_pkg;

	typedef logic [7:0] byte_t; // one z80 data or address byte

	// low address byte of each decoded port
	localparam byte_t PORT_FE     = 8'hFE; // keys, tape in
	localparam byte_t PORT_FD     = 8'hFD; // #7FFD paging, #FFFD sound chip
	localparam byte_t PORT_XT     = 8'hAF; // extended config, index in A15..A8
	localparam byte_t PORT_KJOY   = 8'h1F; // kempston joystick, outside dos
	localparam byte_t PORT_KMOUSE = 8'hDF; // kempston mouse
	localparam byte_t PORT_SDCFG  = 8'h77; // sd card control
	localparam byte_t PORT_SDDAT  = 8'h57; // sd card data

	// #nnAF register indexes, high address byte

	// rampage 0..3 sit at four consecutive indexes
	localparam byte_t XT_RAMPAGE   = 8'h10;
	localparam byte_t XT_FMADDR    = 8'h15;
	localparam byte_t XT_SYSCONF   = 8'h20;
	localparam byte_t XT_MEMCONF   = 8'h21;
	localparam byte_t XT_FDDVIRT   = 8'h29;
	localparam byte_t XT_INTMASK   = 8'h2A;
	localparam byte_t XT_CACHECONF = 8'h2B;

	// read-only indexes
	localparam byte_t XT_XSTAT   = 8'h00; // power-up flag
	localparam byte_t XT_DMASTAT = 8'h27; // dma busy

	// read-back value of an unmapped port, the bus floats high
	localparam byte_t BUS_IDLE = 8'hFF;

	// sd ports are reachable outside dos, or in virtual dos
	function automatic logic sd_allowed(input logic dos, input logic vdos);
		sd_allowed = !dos || vdos;
	endfunction

endpackage
